/* Bender.yml */
package:
  name: uart_top

sources:
  - common/uart_cfg_pkg.sv
  - common/uart_frame_pkg.sv
  - rtl/uart_baud_gen.sv
  - uart_rx/uart_rx.sv
  - uart_tx/uart_tx.sv
  - rtl/uart_top.sv
  - target: test
    files:
      - tests/tb_uart_top.sv

/* common/uart_cfg_pkg.sv */
`default_nettype none

// timing of the serial port, shared by rx and tx
package uart_cfg_pkg;

	// clk cycles per 16x tick
	localparam logic [15:0] CLK_DIV = 16'd4; // 4 x 16 = 64 cycles per bit

	// divider counter, wraps at CLK_DIV-1
	localparam int DIV_CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(CLK_DIV - 1);

	// oversampling within one bit
	localparam int OVERSAMPLE = 16;
	localparam int TICK_CNT_W = $clog2(OVERSAMPLE); // 4 bit tick counter

	// last tick of a bit, moves the bit index on
	localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(OVERSAMPLE - 1);

	// rx looks at the line here, near mid bit
	localparam logic [TICK_CNT_W-1:0] SAMPLE_TICK = TICK_CNT_W'(7);

endpackage

`default_nettype wire

/* common/uart_frame_pkg.sv */
`default_nettype none

// frame format: start, 8 data lsb first, even parity, 1 stop
package uart_frame_pkg;

	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 1;
	localparam int PARITY_EN = 1; // even parity

	localparam int FRAME_BITS = 1 + DATA_BITS + PARITY_EN + STOP_BITS; // 11
	localparam int BIT_IDX_W = $clog2(FRAME_BITS + 1);

	// bit positions in a frame, start bit is index 0
	localparam logic [BIT_IDX_W-1:0] PAR_IDX = BIT_IDX_W'(DATA_BITS + 1);
	localparam logic [BIT_IDX_W-1:0] STOP_IDX = BIT_IDX_W'(FRAME_BITS - 1);

	// one data byte
	typedef logic [DATA_BITS-1:0] data_t;

endpackage

`default_nettype wire

/* list.f */
common/uart_cfg_pkg.sv
common/uart_frame_pkg.sv
rtl/uart_baud_gen.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
rtl/uart_top.sv
tests/tb_uart_top.sv

/* rtl/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// 16x baud tick, one clk cycle wide
module uart_baud_gen (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	logic [uart_cfg_pkg::DIV_CNT_W-1:0] div_cnt; // free running divider

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0; // quiet while in reset
		end else begin
			if (div_cnt == uart_cfg_pkg::DIV_LAST) begin
				div_cnt <= '0;
				tick    <= 1'b1; // pulse on wrap
			end else begin
				div_cnt <= div_cnt + 1'b1;
				tick    <= 1'b0;
			end
		end
	end

	// rx and tx count ticks, so a double pulse would skew every bit
	a_tick_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		tick |=> !tick
	);

endmodule

`default_nettype wire

/* rtl/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

// serial port: shared 16x tick, receiver, transmitter
module uart_top (
	input  logic                  clk,
	input  logic                  rst_n,
	// receive side
	input  logic                  rx_in,
	input  logic                  uld,
	output uart_frame_pkg::data_t rx_data,
	output logic                  byte_rdy,
	output logic                  parity_err,
	output logic                  frame_err,
	output logic                  overrun,
	// transmit side
	input  logic                  tx_start,
	input  uart_frame_pkg::data_t tx_data,
	output logic                  tx_out,
	output logic                  tx_busy
);

	logic tick; // one tick for both directions

	uart_baud_gen uart_baud_gen_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	uart_rx uart_rx_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.tick       (tick),
		.rx_in      (rx_in),  // async, synced inside
		.uld        (uld),
		.rx_data    (rx_data),
		.byte_rdy   (byte_rdy),
		.parity_err (parity_err),
		.frame_err  (frame_err),
		.overrun    (overrun)
	);

	uart_tx uart_tx_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_out   (tx_out),
		.tx_busy  (tx_busy)
	);

endmodule

`default_nettype wire

/* tests/tb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

	localparam int BIT_CYC = uart_cfg_pkg::CLK_DIV * uart_cfg_pkg::OVERSAMPLE; // 64 clk per bit
	localparam int FRAME_CYC = uart_frame_pkg::FRAME_BITS * BIT_CYC;
	localparam int N_LOOP = 30;
	localparam int N_ERR = 8;
	localparam int N_FRAMES = N_LOOP + N_ERR + 8; // extra frames for strobe overrun and glitch
	localparam int WATCHDOG_NS = N_FRAMES * FRAME_CYC * 100 * 2 + 100000;

	logic clk, rst_n, uld, tx_start, tx_out, tx_busy;
	logic byte_rdy, parity_err, frame_err, overrun;
	uart_frame_pkg::data_t tx_data, rx_data;
	logic loop_en; // rx fed from tx_out or else from the bit-banger
	logic bb_line;
	logic rx_line;
	logic [9:0] exp_q[$]; // {parity_err, frame_err, data}
	int errors, checks;

	assign rx_line = loop_en ? tx_out : bb_line;

	uart_top uart_top_inst (
		.clk(clk), .rst_n(rst_n), .rx_in(rx_line), .uld(uld), .rx_data(rx_data),
		.byte_rdy(byte_rdy), .parity_err(parity_err), .frame_err(frame_err),
		.overrun(overrun), .tx_start(tx_start), .tx_data(tx_data),
		.tx_out(tx_out), .tx_busy(tx_busy)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			$display("** Error at %0t: %s, got %h expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	// even parity bit by counting ones
	function automatic logic even_par(input uart_frame_pkg::data_t d);
		int ones;
		ones = 0;
		for (int i = 0; i < uart_frame_pkg::DATA_BITS; i++)
			ones += d[i];
		return ones[0];
	endfunction

	function automatic logic flag_now(input int sel);
		case (sel)
			0: return byte_rdy;
			1: return !tx_busy;
			default: return overrun;
		endcase
	endfunction

	// poll on falling edges and give up after two frame times
	task automatic wait_for(input int sel, input string what);
		int n;
		n = 0;
		while (!flag_now(sel) && n < 2 * FRAME_CYC) begin
			@(negedge clk);
			n++;
		end
		if (!flag_now(sel)) begin
			$display("waited %0d cycles at %0t but %s never happened", n, $time, what);
			errors++;
		end
	endtask

	task automatic send_tx(input uart_frame_pkg::data_t d);
		tx_start = 1'b1;
		tx_data  = d;
		@(negedge clk);
		tx_start = 1'b0;
	endtask

	// drives one 8E1 frame on bb_line with optional corruption
	task automatic bang_frame(input uart_frame_pkg::data_t d, input logic bad_par,
			input logic bad_stop);
		logic [9:0] bits;
		bits = {even_par(d) ^ bad_par, d, 1'b0}; // parity, data, start
		for (int b = 0; b < 10; b++) begin
			bb_line = bits[b];
			repeat (BIT_CYC) @(negedge clk);
		end
		if (bad_stop) begin
			bb_line = 1'b0; // low past the stop sample only
			repeat (40) @(negedge clk);
			bb_line = 1'b1;
			repeat (BIT_CYC - 40) @(negedge clk);
		end else begin
			bb_line = 1'b1;
			repeat (BIT_CYC) @(negedge clk);
		end
	endtask

	// unload and compare with the model's oldest entry
	task automatic recv_check();
		logic [9:0] exp;
		wait_for(0, "byte_rdy rising");
		if (exp_q.size() == 0) begin
			$display("a byte was unloaded at %0t with no frame expected", $time);
			errors++;
			exp = '0;
		end else begin
			exp = exp_q.pop_front();
		end
		uld = 1'b1;
		@(negedge clk);
		uld = 1'b0;
		check(rx_data, exp[7:0], "rx_data");
		check(parity_err, exp[9], "parity_err");
		check(frame_err, exp[8], "frame_err");
		check(byte_rdy, 1'b0, "byte_rdy after uld");
		check(overrun, 1'b0, "overrun after uld");
	endtask

	// byte_rdy must stay low for the whole window
	task automatic idle_check(input int cycles, input string what);
		logic seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			seen |= byte_rdy;
		end
		check(seen, 1'b0, what);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		uart_frame_pkg::data_t d, d2;
		logic [1:0] kind;
		void'($urandom(32'h8428_2166));
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		uld = 1'b0;
		tx_start = 1'b0;
		tx_data = '0;
		bb_line = 1'b1; // mark
		loop_en = 1'b1;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check(tx_out, 1'b1, "tx_out after reset");
		check(byte_rdy, 1'b0, "byte_rdy after reset");
		check(tx_busy, 1'b0, "tx_busy after reset");
		check(overrun, 1'b0, "overrun after reset");

		for (int i = 0; i < N_LOOP; i++) begin // loopback
			d = $urandom;
			exp_q.push_back({2'b00, d});
			send_tx(d);
			wait_for(1, "tx_busy falling");
			recv_check();
		end

		d = $urandom; // second strobe lands while busy
		d2 = ~d;
		exp_q.push_back({2'b00, d});
		send_tx(d);
		check(tx_busy, 1'b1, "tx_busy after strobe");
		repeat (10) @(negedge clk);
		send_tx(d2);
		wait_for(1, "tx_busy falling");
		recv_check();
		idle_check(FRAME_CYC, "byte_rdy from ignored strobe");

		loop_en = 1'b0; // bit-banger from here
		for (int i = 0; i < N_ERR; i++) begin
			d = $urandom;
			kind = i[1:0]; // every corruption mix twice
			exp_q.push_back({kind[0], kind[1], d}); // received parity wrong iff flipped
			bang_frame(d, kind[0], kind[1]);
			recv_check();
		end

		d = $urandom; // overrun as the second frame replaces the first
		d2 = $urandom;
		exp_q.push_back({2'b00, d});
		exp_q.push_back({2'b00, d2});
		bang_frame(d, 1'b0, 1'b0);
		bang_frame(d2, 1'b0, 1'b0);
		wait_for(2, "overrun rising");
		check(overrun, 1'b1, "overrun before uld");
		void'(exp_q.pop_front()); // first byte lost
		recv_check();

		bb_line = 1'b0; // 20 cycle start glitch
		repeat (20) @(negedge clk);
		bb_line = 1'b1;
		idle_check(FRAME_CYC, "byte_rdy after start glitch");
		d = $urandom;
		exp_q.push_back({2'b00, d});
		bang_frame(d, 1'b0, 1'b0);
		recv_check();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* uart_rx/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

// 16x oversampling 8E1 receiver
// byte and status wait in a holding register until uld
module uart_rx (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,
	input  logic                  rx_in,
	input  logic                  uld,
	output uart_frame_pkg::data_t rx_data,
	output logic                  byte_rdy,
	output logic                  parity_err,
	output logic                  frame_err,
	output logic                  overrun
);

	logic rx_meta;  // first sync stage
	logic rx_sync;  // line as seen by the fsm
	logic rx_busy;  // frame in progress
	logic [uart_cfg_pkg::TICK_CNT_W-1:0] tick_cnt;
	logic [uart_frame_pkg::BIT_IDX_W-1:0] bit_idx;
	uart_frame_pkg::data_t rx_reg;    // shift register, lsb arrives first
	uart_frame_pkg::data_t pend_data; // completed byte, not yet unloaded
	logic par_bad;      // parity check of frame in flight
	logic pend_par_err;
	logic pend_frm_err;
	logic sample;       // mid bit sample strobe
	logic frame_done;   // stop bit sampled

	assign sample     = rx_busy && tick && (tick_cnt == uart_cfg_pkg::SAMPLE_TICK);
	assign frame_done = sample && (bit_idx == uart_frame_pkg::STOP_IDX);

	// two flop synchronizer idling at mark
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
		end
	end

	// idle/busy fsm with tick counter and bit index
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_busy  <= 1'b0;
			tick_cnt <= '0;
			bit_idx  <= '0;
			par_bad  <= 1'b0;
		end else if (!rx_busy) begin
			rx_busy  <= ~rx_sync; // space on idle line = start
			tick_cnt <= '0;
			bit_idx  <= '0;
		end else if (tick) begin
			tick_cnt <= tick_cnt + 1'b1; // wraps at 16
			if (tick_cnt == uart_cfg_pkg::TICK_LAST)
				bit_idx <= bit_idx + 1'b1;
			if (tick_cnt == uart_cfg_pkg::SAMPLE_TICK) begin
				if (bit_idx == '0)
					rx_busy <= ~rx_sync; // high again means a glitch so drop it
				else if (bit_idx == uart_frame_pkg::PAR_IDX)
					par_bad <= rx_sync ^ (^rx_reg); // even parity over data
				else if (bit_idx == uart_frame_pkg::STOP_IDX)
					rx_busy <= 1'b0; // back to idle mid stop bit
			end
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (sample && (bit_idx != '0) && (bit_idx < uart_frame_pkg::PAR_IDX))
			rx_reg <= {rx_sync, rx_reg[uart_frame_pkg::DATA_BITS-1:1]};
		if (frame_done)
			pend_data <= rx_reg; // newer frame overwrites unread one
		if (uld)
			rx_data <= pend_data;
	end

	// handshake and status
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_rdy     <= 1'b0;
			overrun      <= 1'b0;
			pend_par_err <= 1'b0;
			pend_frm_err <= 1'b0;
			parity_err   <= 1'b0;
			frame_err    <= 1'b0;
		end else begin
			if (frame_done) begin
				pend_par_err <= par_bad;
				pend_frm_err <= ~rx_sync; // stop must be mark
			end
			if (uld) begin
				parity_err <= pend_par_err;
				frame_err  <= pend_frm_err;
			end
			if (frame_done)
				byte_rdy <= 1'b1; // wins over a same cycle uld
			else if (uld)
				byte_rdy <= 1'b0;
			if (uld)
				overrun <= 1'b0;
			else if (frame_done && byte_rdy)
				overrun <= 1'b1; // sticky until next unload
		end
	end

	// bit index stays inside the frame since stop handling ends it
	a_bit_idx_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		bit_idx < uart_frame_pkg::FRAME_BITS
	);

	// a raised overrun always has a byte pending behind it
	a_overrun_pending: assert property (
		@(posedge clk) disable iff (!rst_n)
		overrun |-> byte_rdy
	);

endmodule

`default_nettype wire

/* uart_tx/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

// transmitter, one 8E1 frame per accepted start strobe
module uart_tx (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,
	input  logic                  tx_start,
	input  uart_frame_pkg::data_t tx_data,
	output logic                  tx_out,
	output logic                  tx_busy
);

	logic [uart_frame_pkg::FRAME_BITS-1:0] tx_shreg; // frame, lsb goes out first
	logic armed;  // accepted, start bit goes out on next tick
	logic accept; // strobe while idle
	logic bit_end; // last tick of current bit
	logic [uart_cfg_pkg::TICK_CNT_W-1:0] tick_cnt;
	logic [uart_frame_pkg::BIT_IDX_W-1:0] bit_idx;

	assign accept  = tx_start && !tx_busy; // strobes while busy are dropped
	assign bit_end = tx_busy && !armed && tick && (tick_cnt == uart_cfg_pkg::TICK_LAST);

	// frame shift register
	always_ff @(posedge clk) begin
		if (accept)
			tx_shreg <= {1'b1, ^tx_data, tx_data, 1'b0}; // stop, parity, data, start
		else if (bit_end)
			tx_shreg <= {1'b1, tx_shreg[uart_frame_pkg::FRAME_BITS-1:1]};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_busy  <= 1'b0;
			armed    <= 1'b0;
			tick_cnt <= '0;
			bit_idx  <= '0;
			tx_out   <= 1'b1; // mark
		end else if (accept) begin
			tx_busy  <= 1'b1;
			armed    <= 1'b1;
			tick_cnt <= '0;
			bit_idx  <= '0;
		end else if (tx_busy && tick) begin
			if (armed) begin
				armed  <= 1'b0;
				tx_out <= tx_shreg[0]; // start bit
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
				if (tick_cnt == uart_cfg_pkg::TICK_LAST) begin
					if (bit_idx == uart_frame_pkg::STOP_IDX) begin
						tx_busy <= 1'b0; // stop bit done
						tx_out  <= 1'b1;
					end else begin
						bit_idx <= bit_idx + 1'b1;
						tx_out  <= tx_shreg[1]; // next bit
					end
				end
			end
		end
	end

	// line idles at mark outside a frame
	a_idle_mark: assert property (
		@(posedge clk) disable iff (!rst_n)
		!tx_busy |-> tx_out
	);

endmodule

`default_nettype wire
